/* src/system86MainPkg.sv */
package system86MainPkg;

	////////////////////
	// Bus widths
	////////////////////

	// 6809 main CPU bus
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	////////////////////
	// Address map
	////////////////////

	// Decoded region of one CPU access
	typedef enum logic [3:0] {
		RGN_SPRITE,   // 0000-1FFF read/write
		RGN_VRAM1,    // 2000-3FFF read/write
		RGN_VRAM2,    // 4000-5FFF read/write
		RGN_EEPROM,   // 6000-7FFF read only
		RGN_ROM,      // 8000-FFFF read only
		RGN_WDOG,     // Write to 8000-87FF
		RGN_IRQACK,   // Write to 8800-8FFF
		RGN_LATCH0,   // Write to D000-D7FF
		RGN_LATCH1,   // Write to D800-DFFF
		RGN_NONE      // Any other write
	} regionE;

	////////////////////
	// Watchdog
	////////////////////

	typedef enum logic {
		WD_RUN,
		WD_RESET
	} wdStateE;

	// VBLANK periods the main reset is held low after a fire
	localparam int WDOG_HOLD = 2;

	////////////////////
	// Latch group offsets
	////////////////////

	// Register select on address bits 2..0
	// Layer A
	localparam logic [2:0] OFS_PRIO_A    = 3'd0;  // Priority 7..5, scroll X bit 8 in bit 0
	localparam logic [2:0] OFS_SCROLLX_A = 3'd1;
	localparam logic [2:0] OFS_SCROLLY_A = 3'd2;
	// Shared ROM bank
	localparam logic [2:0] OFS_ROMBANK   = 3'd3;
	// Layer B, same layout as layer A
	localparam logic [2:0] OFS_PRIO_B    = 3'd4;
	localparam logic [2:0] OFS_SCROLLX_B = 3'd5;
	localparam logic [2:0] OFS_SCROLLY_B = 3'd6;
	// No register here
	localparam logic [2:0] OFS_UNUSED    = 3'd7;

endpackage

/* src/cpuBusIf.sv */
`timescale 1ns/1ps

interface cpuBusIf;
	import system86MainPkg::*;

	// One access, present only while valid is high
	logic [ADDR_W-1:0] addr;
	logic write;
	logic [DATA_W-1:0] wdata;
	// No handshake, the 6809 never waits
	logic valid;

	////////////////////
	// Modports
	////////////////////

	// Address decoder looks at address and direction
	modport decode (
		input addr,
		input write,
		input valid
	);

	// Latch groups take the data and the register select bits
	modport sink (
		input wdata,
		input addr
	);

endinterface

/* src/mainAddrDecoder.sv */
`timescale 1ns/1ps

module mainAddrDecoder (
	cpuBusIf.decode bus,
	// Memory chip selects, active low
	output logic mcs0N,
	output logic mcs1N,
	output logic mcs2N,
	output logic mcs4N,
	output logic mromN,
	output system86MainPkg::regionE region,
	// Internal write strobes
	output logic wdogKick,
	output logic intAck,
	output logic [1:0] latchWrite
);
	import system86MainPkg::*;

	// Top five address bits, 2 KB pages
	logic [4:0] page;

	assign page = bus.addr[ADDR_W-1 -: 5];

	////////////////////
	// Region decode
	////////////////////

	// Follows the address every cycle, valid plays no part here
	always_comb begin
		region = RGN_NONE;
		case (page[4:2])
			// 0000-1FFF sprite RAM
			3'b000: region = RGN_SPRITE;
			// 2000-3FFF video RAM 1
			3'b001: region = RGN_VRAM1;
			// 4000-5FFF video RAM 2
			3'b010: region = RGN_VRAM2;
			// 6000-7FFF EEPROM, reads only
			3'b011: begin
				if (!bus.write) begin
					region = RGN_EEPROM;
				end
			end
			// Upper half is ROM for reads
			default: begin
				if (!bus.write) begin
					region = RGN_ROM;
				end else begin
					// Writes into ROM space hit the internal registers
					case (page)
						5'b10000: region = RGN_WDOG;
						5'b10001: region = RGN_IRQACK;
						5'b11010: region = RGN_LATCH0;
						5'b11011: region = RGN_LATCH1;
						default: region = RGN_NONE;
					endcase
				end
			end
		endcase
	end

	////////////////////
	// Chip selects
	////////////////////

	// At most one low, region is a single value
	assign mcs2N = (region != RGN_SPRITE);
	assign mcs0N = (region != RGN_VRAM1);
	assign mcs1N = (region != RGN_VRAM2);
	// Read only devices, write already folded into region
	assign mcs4N = (region != RGN_EEPROM);
	assign mromN = (region != RGN_ROM);

	////////////////////
	// Write strobes
	////////////////////

	// One clock wide, qualified by the access itself
	assign wdogKick = bus.valid && (region == RGN_WDOG);
	assign intAck = bus.valid && (region == RGN_IRQACK);

	// One strobe per scroll/priority group
	assign latchWrite[0] = bus.valid && (region == RGN_LATCH0);
	assign latchWrite[1] = bus.valid && (region == RGN_LATCH1);

endmodule

/* src/mainTimingCtrl.sv */
`timescale 1ns/1ps

module mainTimingCtrl #(
	parameter int WDOG_LIMIT = 8
) (
	input logic clk6M,
	input logic rstN,
	input logic clk0,
	input logic vblankN,
	input logic wdogKick,
	input logic intAck,
	output logic q,
	output logic mresetN,
	output logic mintN
);
	import system86MainPkg::*;

	// Wide enough for WDOG_LIMIT, hold count reuses it
	localparam int CNT_W = $clog2(WDOG_LIMIT + 1);

	logic [3:0] phase;
	logic [1:0] vbSync;
	logic vbLast;
	logic vbFall;
	logic [CNT_W-1:0] wdCount;
	wdStateE wdState;

	////////////////////
	// CPU clock phase
	////////////////////

	// Free running while clk0 high, parked at zero otherwise
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			phase <= '0;
		end else if (!clk0) begin
			phase <= '0;
		end else begin
			phase <= phase + 4'd1;
		end
	end

	// Quadrature output, low at phase zero
	assign q = phase[1] ^ phase[0];

	////////////////////
	// VBLANK edge
	////////////////////

	// Two stage synchroniser, then a delayed copy for the edge
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			vbSync <= 2'b11;
			vbLast <= 1'b1;
			vbFall <= 1'b0;
		end else begin
			vbSync <= {vbSync[0], vblankN};
			vbLast <= vbSync[1];
			// Registered pulse, one cycle per frame
			vbFall <= vbLast & ~vbSync[1];
		end
	end

	////////////////////
	// Interrupt
	////////////////////

	// Acknowledge wins over a new edge in the same cycle
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			mintN <= 1'b1;
		end else if (intAck) begin
			mintN <= 1'b1;
		end else if (vbFall) begin
			mintN <= 1'b0;
		end
	end

	////////////////////
	// Watchdog
	////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			wdState <= WD_RUN;
			wdCount <= '0;
			mresetN <= 1'b1;
		end else begin
			case (wdState)
				WD_RUN: begin
					if (wdCount == CNT_W'(WDOG_LIMIT)) begin
						// Timed out, pull main reset and start the hold count
						wdState <= WD_RESET;
						wdCount <= '0;
						mresetN <= 1'b0;
					end else if (wdogKick) begin
						wdCount <= '0;
					end else if (vbFall) begin
						wdCount <= wdCount + 1'b1;
					end
				end
				WD_RESET: begin
					// Kicks ignored, the CPU is held in reset
					if (vbFall) begin
						if (wdCount == CNT_W'(WDOG_HOLD - 1)) begin
							wdState <= WD_RUN;
							wdCount <= '0;
							mresetN <= 1'b1;
						end else begin
							wdCount <= wdCount + 1'b1;
						end
					end
				end
				default: begin
					wdState <= WD_RUN;
					wdCount <= '0;
					mresetN <= 1'b1;
				end
			endcase
		end
	end

endmodule

/* src/scrollLatchBank.sv */
`timescale 1ns/1ps

module scrollLatchBank (
	input logic clk6M,
	input logic rstN,
	input logic latchWrite,
	cpuBusIf.sink bus,
	// Layer scroll positions
	output logic [8:0] scrollXA,
	output logic [8:0] scrollXB,
	output logic [7:0] scrollYA,
	output logic [7:0] scrollYB,
	// Layer priorities
	output logic [2:0] priorityA,
	output logic [2:0] priorityB,
	output logic [7:0] romBank
);
	import system86MainPkg::*;

	// Register select and write data
	logic [2:0] sel;
	logic [DATA_W-1:0] data;

	assign sel = bus.addr[2:0];
	assign data = bus.wdata;

	////////////////////
	// Register file
	////////////////////

	// Cleared on reset so both layers start unscrolled
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			scrollXA <= '0;
			scrollXB <= '0;
			scrollYA <= '0;
			scrollYB <= '0;
			priorityA <= '0;
			priorityB <= '0;
			romBank <= '0;
		end else if (latchWrite) begin
			case (sel)
				// Priority in the top bits, scroll X MSB in bit 0
				OFS_PRIO_A: begin
					priorityA <= data[7:5];
					scrollXA[8] <= data[0];
				end
				OFS_SCROLLX_A: begin
					scrollXA[7:0] <= data;
				end
				OFS_SCROLLY_A: begin
					scrollYA <= data;
				end
				// Bank for this group's tile ROM
				OFS_ROMBANK: begin
					romBank <= data;
				end
				// Layer B mirrors layer A
				OFS_PRIO_B: begin
					priorityB <= data[7:5];
					scrollXB[8] <= data[0];
				end
				OFS_SCROLLX_B: begin
					scrollXB[7:0] <= data;
				end
				OFS_SCROLLY_B: begin
					scrollYB <= data;
				end
				// Nothing behind offset 7
				OFS_UNUSED: begin
					romBank <= romBank;
				end
				default: begin
					romBank <= romBank;
				end
			endcase
		end
	end

endmodule

/* src/system86MainBus.sv */
`timescale 1ns/1ps

module system86MainBus #(
	parameter int WDOG_LIMIT = 8
) (
	input logic clk6M,
	input logic rstN,
	input logic clk0,
	input logic vblankN,
	// Main CPU bus
	input logic busValid,
	input logic busWrite,
	input logic [system86MainPkg::ADDR_W-1:0] busAddr,
	input logic [system86MainPkg::DATA_W-1:0] busWdata,
	// Memory chip selects
	output logic mcs0N,
	output logic mcs1N,
	output logic mcs2N,
	output logic mcs4N,
	output logic mromN,
	// CPU clock, reset and interrupt
	output logic q,
	output logic mresetN,
	output logic mintN,
	// Latch group 0
	output logic [8:0] scrollXA0,
	output logic [8:0] scrollXB0,
	output logic [7:0] scrollYA0,
	output logic [7:0] scrollYB0,
	output logic [2:0] priorityA0,
	output logic [2:0] priorityB0,
	output logic [7:0] romBank0,
	// Latch group 1
	output logic [8:0] scrollXA1,
	output logic [8:0] scrollXB1,
	output logic [7:0] scrollYA1,
	output logic [7:0] scrollYB1,
	output logic [2:0] priorityA1,
	output logic [2:0] priorityB1,
	output logic [7:0] romBank1
);
	import system86MainPkg::*;

	regionE region;
	logic wdogKick;
	logic intAck;
	logic [1:0] latchWrite;

	////////////////////
	// Bus bundle
	////////////////////

	cpuBusIf busIf ();

	assign busIf.addr = busAddr;
	assign busIf.write = busWrite;
	assign busIf.wdata = busWdata;
	assign busIf.valid = busValid;

	////////////////////
	// Blocks
	////////////////////

	// Address map and strobes
	mainAddrDecoder u_dec (
		.bus(busIf.decode), .mcs0N(mcs0N), .mcs1N(mcs1N), .mcs2N(mcs2N),
		.mcs4N(mcs4N), .mromN(mromN), .region(region),
		.wdogKick(wdogKick), .intAck(intAck), .latchWrite(latchWrite)
	);

	// Phase, interrupt and watchdog
	mainTimingCtrl #(.WDOG_LIMIT(WDOG_LIMIT)) u_timing (
		.clk6M(clk6M), .rstN(rstN), .clk0(clk0), .vblankN(vblankN),
		.wdogKick(wdogKick), .intAck(intAck),
		.q(q), .mresetN(mresetN), .mintN(mintN)
	);

	// D000-D7FF group
	scrollLatchBank u_latch0 (
		.clk6M(clk6M), .rstN(rstN), .latchWrite(latchWrite[0]), .bus(busIf.sink),
		.scrollXA(scrollXA0), .scrollXB(scrollXB0), .scrollYA(scrollYA0),
		.scrollYB(scrollYB0), .priorityA(priorityA0), .priorityB(priorityB0),
		.romBank(romBank0)
	);

	// D800-DFFF group
	scrollLatchBank u_latch1 (
		.clk6M(clk6M), .rstN(rstN), .latchWrite(latchWrite[1]), .bus(busIf.sink),
		.scrollXA(scrollXA1), .scrollXB(scrollXB1), .scrollYA(scrollYA1),
		.scrollYB(scrollYB1), .priorityA(priorityA1), .priorityB(priorityB1),
		.romBank(romBank1)
	);

endmodule

/* verification/system86MainBus_chk.sv */
`timescale 1ns/1ps

module system86MainBus_chk (
	input logic clk6M,
	input logic rstN,
	input logic busValid,
	input logic busWrite,
	input logic mcs0N,
	input logic mcs1N,
	input logic mcs2N,
	input logic mcs4N,
	input logic mromN,
	input logic q,
	input logic mresetN,
	input logic mintN,
	input system86MainPkg::regionE region,
	input system86MainPkg::wdStateE wdState
);
	import system86MainPkg::*;

	////////////////////
	// Chip selects
	////////////////////

	// Never two memory devices on the bus
	onehotSel: assert property (@(posedge clk6M)
		$countones({~mcs0N, ~mcs1N, ~mcs2N, ~mcs4N, ~mromN}) <= 1)
		else $error("More than one memory chip select active");

	// EEPROM and ROM only answer reads
	noRomWrite: assert property (@(posedge clk6M) busWrite |-> (mcs4N && mromN))
		else $error("EEPROM or ROM selected on a write");

	////////////////////
	// Reset and watchdog
	////////////////////

	// Outputs parked while the board reset is held
	resetState: assert property (@(posedge clk6M) !rstN |-> (mresetN && mintN && !q))
		else $error("Outputs not at reset values during reset");

	// Main reset stays high while the watchdog runs
	runNoReset: assert property (@(posedge clk6M) (wdState == WD_RUN) |-> mresetN)
		else $error("Main reset low while the watchdog is running");

	// Acknowledge always clears the interrupt
	ackClears: assert property (@(posedge clk6M) disable iff (!rstN)
		(busValid && region == RGN_IRQACK) |=> mintN)
		else $error("Interrupt still pending after an acknowledge write");

endmodule

bind system86MainBus system86MainBus_chk u_chk (
	.clk6M(clk6M), .rstN(rstN), .busValid(busValid), .busWrite(busWrite),
	.mcs0N(mcs0N), .mcs1N(mcs1N), .mcs2N(mcs2N), .mcs4N(mcs4N), .mromN(mromN),
	.q(q), .mresetN(mresetN), .mintN(mintN),
	.region(region), .wdState(u_timing.wdState)
);

/* verification/system86MainBusTb.sv */
`timescale 1ns/1ps

module system86MainBusTb;

	localparam int WDOG_LIMIT = 8;
	// VBLANK edges the main reset stays low after a fire
	localparam int HOLD_EDGES = 2;

	// Phase lengths in clock cycles
	localparam int RESET_CYCLES = 8;
	localparam int N_RANDOM = 200;
	localparam int LATCH_CYCLES = 40;
	localparam int N_KEEP = 20;
	localparam int N_FIRE = 12;
	localparam int FRAME_CYCLES = 20;
	localparam int N_CLOCK = 100;
	localparam int TEST_CYCLES = RESET_CYCLES + 2 + N_RANDOM + LATCH_CYCLES
		+ (N_KEEP + N_FIRE) * FRAME_CYCLES + N_CLOCK;
	// Four times the expected run at 4 ns per cycle
	localparam int TIMEOUT_NS = 4 * TEST_CYCLES * 4;

	logic clk6M = 1'b0;
	logic rstN;
	logic clk0;
	logic vblankN;
	logic busValid;
	logic busWrite;
	logic [15:0] busAddr;
	logic [7:0] busWdata;
	logic mcs0N, mcs1N, mcs2N, mcs4N, mromN;
	logic q, mresetN, mintN;
	logic [8:0] scrollXA0, scrollXB0, scrollXA1, scrollXB1;
	logic [7:0] scrollYA0, scrollYB0, scrollYA1, scrollYB1;
	logic [2:0] priorityA0, priorityB0, priorityA1, priorityB1;
	logic [7:0] romBank0, romBank1;

	// Shadow latch registers indexed by group
	logic [8:0] shXA [2];
	logic [8:0] shXB [2];
	logic [7:0] shYA [2];
	logic [7:0] shYB [2];
	logic [2:0] shPrA [2];
	logic [2:0] shPrB [2];
	logic [7:0] shBank [2];

	// Watchdog model
	int wdEdges = 0;
	int holdEdges = 0;
	logic wdHeld = 1'b0;

	int seed = 30286;

	system86MainBus #(.WDOG_LIMIT(WDOG_LIMIT)) u_dut (.*);

	always #2 clk6M = ~clk6M;

	////////////////////
	// Helpers
	////////////////////

	task automatic stopRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic expectEq(input logic [63:0] got, input logic [63:0] exp, input string what);
		assert (got === exp)
		else stopRun($sformatf("FAIL %0.1f ns: %s is %0h, expected %0h",
			$realtime, what, got, exp));
	endtask

	function automatic logic [31:0] nextRand();
		return $random(seed);
	endfunction

	// Drive point half a nanosecond past the rising edge
	task automatic waitDrive();
		@(posedge clk6M);
		#0.5;
	endtask

	// Expected selects in order mcs2N, mcs0N, mcs1N, mcs4N, mromN
	function automatic logic [4:0] expectedSelects(input logic [15:0] a, input logic wr);
		logic [4:0] sel;
		sel = 5'b11111;
		if (a < 16'h2000) begin
			sel[4] = 1'b0;
		end else if (a < 16'h4000) begin
			sel[3] = 1'b0;
		end else if (a < 16'h6000) begin
			sel[2] = 1'b0;
		end else if (!wr) begin
			if (a < 16'h8000) begin
				sel[1] = 1'b0;
			end else begin
				sel[0] = 1'b0;
			end
		end
		return sel;
	endfunction

	task automatic applyLatch(input logic grp, input logic [2:0] ofs, input logic [7:0] d);
		case (ofs)
			3'd0: begin
				shPrA[grp] = d[7:5];
				shXA[grp][8] = d[0];
			end
			3'd1: shXA[grp][7:0] = d;
			3'd2: shYA[grp] = d;
			3'd3: shBank[grp] = d;
			3'd4: begin
				shPrB[grp] = d[7:5];
				shXB[grp][8] = d[0];
			end
			3'd5: shXB[grp][7:0] = d;
			3'd6: shYB[grp] = d;
			// Offset 7 has no register
			default: begin
			end
		endcase
	endtask

	task automatic checkLatches();
		expectEq(64'({scrollXA0, scrollXB0, scrollYA0, scrollYB0, priorityA0, priorityB0,
			romBank0}), 64'({shXA[0], shXB[0], shYA[0], shYB[0], shPrA[0], shPrB[0],
			shBank[0]}), "latch group 0");
		expectEq(64'({scrollXA1, scrollXB1, scrollYA1, scrollYB1, priorityA1, priorityB1,
			romBank1}), 64'({shXA[1], shXB[1], shYA[1], shYB[1], shPrA[1], shPrB[1],
			shBank[1]}), "latch group 1");
	endtask

	task automatic checkResetState();
		expectEq(64'(mresetN), 64'd1, "mresetN");
		expectEq(64'(mintN), 64'd1, "mintN");
		expectEq(64'(q), 64'd0, "q");
		checkLatches();
	endtask

	// One CPU cycle that returns at the next drive point
	task automatic busAccess(input logic v, input logic wr, input logic [15:0] a,
		input logic [7:0] d);
		logic [4:0] exp;
		logic ack;
		busValid = v;
		busWrite = wr;
		busAddr = a;
		busWdata = d;
		exp = expectedSelects(a, wr);
		ack = v && wr && (a >= 16'h8800) && (a <= 16'h8FFF);
		@(negedge clk6M);
		expectEq(64'({mcs2N, mcs0N, mcs1N, mcs4N, mromN}), 64'(exp),
			$sformatf("chip selects for %h", a));
		if (v && wr) begin
			if (a >= 16'hD000 && a <= 16'hDFFF) begin
				applyLatch(a[11], a[2:0], d);
			end
			// Kicks only count while the CPU runs
			if (a >= 16'h8000 && a <= 16'h87FF && !wdHeld) begin
				wdEdges = 0;
			end
		end
		waitDrive();
		busValid = 1'b0;
		checkLatches();
		if (ack) begin
			expectEq(64'(mintN), 64'd1, "mintN after acknowledge");
		end
	endtask

	// Watchdog model on one VBLANK falling edge
	task automatic frameEdge();
		if (wdHeld) begin
			holdEdges++;
			if (holdEdges == HOLD_EDGES) begin
				wdHeld = 1'b0;
				wdEdges = 0;
			end
		end else begin
			wdEdges++;
			if (wdEdges == WDOG_LIMIT) begin
				wdHeld = 1'b1;
				holdEdges = 0;
			end
		end
	endtask

	task automatic runFrame(input logic kick);
		int n;
		logic [31:0] r;
		vblankN = 1'b0;
		n = 0;
		while (mintN == 1'b1 && n < 4) begin
			waitDrive();
			n++;
		end
		expectEq(64'(mintN), 64'd0, "mintN after VBLANK fall");
		frameEdge();
		repeat (8 - n) waitDrive();
		expectEq(64'(mresetN), 64'(!wdHeld), "mresetN after VBLANK");
		expectEq(64'(mintN), 64'd0, "mintN before acknowledge");
		vblankN = 1'b1;
		r = nextRand();
		if (kick) begin
			busAccess(1'b1, 1'b1, 16'h8000, r[7:0]);
			// A kick leaves the interrupt pending
			expectEq(64'(mintN), 64'd0, "mintN after kick");
		end
		busAccess(1'b1, 1'b1, 16'h8800, r[15:8]);
		repeat (6) waitDrive();
		expectEq(64'(mresetN), 64'(!wdHeld), "mresetN at frame end");
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		logic [31:0] r;
		logic [3:0] cnt;
		rstN = 1'b1;
		clk0 = 1'b0;
		vblankN = 1'b1;
		busValid = 1'b0;
		busWrite = 1'b0;
		busAddr = '0;
		busWdata = '0;
		for (int g = 0; g < 2; g++) begin
			shXA[g] = '0;
			shXB[g] = '0;
			shYA[g] = '0;
			shYB[g] = '0;
			shPrA[g] = '0;
			shPrB[g] = '0;
			shBank[g] = '0;
		end

		// Board reset with outputs checked throughout
		#0.5;
		rstN = 1'b0;
		repeat (RESET_CYCLES) begin
			waitDrive();
			checkResetState();
		end
		rstN = 1'b1;
		waitDrive();
		checkResetState();

		// Random accesses over the whole map
		repeat (N_RANDOM) begin
			r = nextRand();
			busAccess(r[16], r[17], r[15:0], r[25:18]);
		end

		// Every latch offset in both groups
		for (int g = 0; g < 2; g++) begin
			for (int o = 0; o < 8; o++) begin
				r = nextRand();
				busAccess(1'b1, 1'b1, {4'hD, g[0], 8'h00, o[2:0]}, r[7:0]);
			end
		end
		// Same writes without valid
		for (int g = 0; g < 2; g++) begin
			for (int o = 0; o < 8; o++) begin
				r = nextRand();
				busAccess(1'b0, 1'b1, {4'hD, g[0], 8'h00, o[2:0]}, r[7:0]);
			end
		end

		// Kicked frames then a starved watchdog
		repeat (N_KEEP) runFrame(1'b1);
		repeat (N_FIRE) runFrame(1'b0);

		// CPU clock phase against a local counter
		cnt = '0;
		repeat (N_CLOCK) begin
			r = nextRand();
			clk0 = (r[1:0] != 2'b00);
			@(posedge clk6M);
			if (clk0) begin
				cnt = cnt + 4'd1;
			end else begin
				cnt = '0;
			end
			#0.5;
			expectEq(64'(q), 64'(cnt[1] ^ cnt[0]), "q");
		end
		clk0 = 1'b0;

		waitDrive();
		$display(">>> PASS");
		$finish;
	end

	// Watchdog on the whole run
	initial begin
		#(TIMEOUT_NS);
		stopRun("Timeout: the test sequence did not finish in time");
	end

endmodule

/* system86MainBus.f */
src/system86MainPkg.sv
src/cpuBusIf.sv
src/mainAddrDecoder.sv
src/mainTimingCtrl.sv
src/scrollLatchBank.sv
src/system86MainBus.sv
verification/system86MainBus_chk.sv
verification/system86MainBusTb.sv

/* run.sh */
#!/bin/sh
# Build and run the System86 main bus testbench with Verilator
# Any failing check ends the simulation with a non-zero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f system86MainBus.f \
	--top-module system86MainBusTb \
	-o system86MainBusSim

./obj_dir/system86MainBusSim
